/* tb/soc_mmio_stim.txt */
// op addr wdata wstrb exp_rdata gpio_in pins exp_out exp_oeb exp_pub exp_pdb exp_irq
// op 1 read, 2 write, 3 pad check; pins bit 0 xtal, 1 pll, 2 trap, 3 irq_pin, 4 irq_spi
3 00000000 00000000 0 00000000 0000 00 0000 ffff 0000 0000 00000000
1 03000004 00000000 0 0000ffff 0000 00 0000 0000 0000 0000 00000000
2 03000000 0000a5c3 f 00000000 0000 00 0000 0000 0000 0000 00000000
2 03000000 00001e00 2 00000000 0000 00 0000 0000 0000 0000 00000000
2 03000004 000000f0 1 00000000 0000 00 0000 0000 0000 0000 00000000
2 03000008 00001234 3 00000000 0000 00 0000 0000 0000 0000 00000000
2 0300000c 0000abcd 2 00000000 0000 00 0000 0000 0000 0000 00000000
1 03000000 00000000 0 1ec30f0f 0f0f 00 0000 0000 0000 0000 00000000
1 0300000c 00000000 0 0000ab00 0000 00 0000 0000 0000 0000 00000000
2 03000034 00000002 1 00000000 0000 00 0000 0000 0000 0000 00000000
2 0300003c 00000003 1 00000000 0000 00 0000 0000 0000 0000 00000000
3 00000000 00000000 0 00000000 0000 04 3e83 c710 3af4 bbe0 00000000
3 00000000 00000000 0 00000000 0000 01 1ec3 c710 3af4 bbe0 00000000
2 03000034 00000000 1 00000000 0000 00 0000 0000 0000 0000 00000000
2 0300003c 00000000 1 00000000 0000 00 0000 0000 0000 0000 00000000
2 03000040 00000002 1 00000000 0000 00 0000 0000 0000 0000 00000000
2 03000044 00000003 1 00000000 0000 00 0000 0000 0000 0000 00000000
3 00000000 00000000 0 00000000 0022 0d 1ec3 fff0 1234 ab00 000001a0
3 00000000 00000000 0 00000000 0001 10 1ec3 fff0 1234 ab00 00000040
2 00000100 11223344 f 00000000 0000 00 0000 0000 0000 0000 00000000
2 00000100 aabbccdd 5 00000000 0000 00 0000 0000 0000 0000 00000000
1 00000100 00000000 0 11bb33dd 0000 00 0000 0000 0000 0000 00000000
1 03000018 00000000 0 0000005a 0000 00 0000 0000 0000 0000 00000000
1 03000024 00000000 0 00000456 0000 00 0000 0000 0000 0000 00000000
1 0300002c 00000000 0 00000002 0000 00 0000 0000 0000 0000 00000000
1 00001000 00000000 0 00000000 0000 00 0000 0000 0000 0000 00000000

/* filelist.f */
source/soc_pkg.sv
source/mem_bus_decoder.sv
source/sysctl_regs.sv
source/gpio_pin_mux.sv
source/soc_mmio_top.sv
tb/tb_soc_mmio.sv

/* Makefile */
# Verilator build and run for the soc mmio block and its testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_mmio
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
PASS_MSG  ?= Simulation finished: PASS
VFLAGS    ?= --timing --assert

SOURCES := $(wildcard source/*.sv tb/*.sv) tb/soc_mmio_stim.txt
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -j $(JOBS)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_soc_mmio.sv */
// testbench for soc_mmio_top, replays tb/soc_mmio_stim.txt against an sram model and checks the DUT
module tb_soc_mmio
  import soc_pkg::*;
();

  localparam int unsigned MEM_WORDS    = 1024;
  localparam int unsigned RAM_AW       = 10;
  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned DRIVE_DLY    = 10;
  localparam int unsigned FIELDS       = 12;
  localparam int unsigned MAX_LINES    = 64;

  // op is 1 for a read, 2 for a write and 3 for a pad check
  typedef struct packed {
    word_t op;
    word_t addr;
    word_t wdata;
    word_t wstrb;
    word_t exp_rdata;
    word_t gpio_in;
    word_t pins;
    word_t exp_out;
    word_t exp_oeb;
    word_t exp_pub;
    word_t exp_pdb;
    word_t exp_irq;
  } stim_line_t;

  logic       clk_i = 1'b0;
  logic       rst_n_i;
  bus_req_t   bus_req_i;
  logic       bus_ready_o;
  word_t      bus_rdata_o;
  word_t      ram_addr_o;
  word_t      ram_wdata_o;
  word_t      ram_rdata_i;
  word_t      irq_o;
  strb_t      ram_wstrb_o;
  gpio_t      gpio_in_i;
  gpio_t      gpio_out_o;
  gpio_t      gpio_outenb_o;
  gpio_t      gpio_pullupb_o;
  gpio_t      gpio_pulldownb_o;
  chip_info_t chip_info_i;
  logic       xtal_in_i;
  logic       clk_pll_i;
  logic       trap_i;
  logic       irq_pin_i;
  logic       irq_spi_i;

  word_t             stim [FIELDS*MAX_LINES];
  logic [31:0]       sram [MEM_WORDS];
  logic [RAM_AW-1:0] sram_idx;
  word_t             sram_rd;
  int unsigned       n_lines;
  int unsigned       cycle_count = 0;
  int unsigned       timeout_limit = 1000;
  int unsigned       mismatch_count = 0;
  int unsigned       other_count = 0;

  soc_mmio_top #(.MEM_WORDS(MEM_WORDS)) dut (.*);

  always #50 clk_i = ~clk_i;

  // sram reads one cycle after the address and writes bytes on the strobes
  always @(posedge clk_i) begin
    sram_idx = ram_addr_o[RAM_AW-1:0];
    sram_rd  = sram[sram_idx];
    for (int b = 0; b < 4; b++) begin
      if (ram_wstrb_o[b]) begin
        sram[sram_idx][8*b +: 8] = ram_wdata_o[8*b +: 8];
      end
    end
    ram_rdata_i <= #DRIVE_DLY sram_rd;
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= timeout_limit) begin
      other_count++;
      $display("error: run did not finish within %0d cycles", timeout_limit);
      $display("checks done: %0d mismatches, %0d other errors", mismatch_count, other_count);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic stim_line_t fetch_line(int unsigned ln);
    logic [FIELDS*32-1:0] bits;
    for (int k = 0; k < FIELDS; k++) begin
      bits[(FIELDS-1-k)*32 +: 32] = stim[ln*FIELDS + k];
    end
    return stim_line_t'(bits);
  endfunction

  task automatic compare_value(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      mismatch_count++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // starts and returns a short delay after a rising edge
  task automatic bus_access(input word_t req_addr, input word_t req_wdata,
                            input strb_t req_wstrb, output word_t rdata);
    int unsigned waited;
    logic        to_ram;
    to_ram    = req_addr < 4 * MEM_WORDS;
    bus_req_i = '{valid: 1'b1, addr: req_addr, wdata: req_wdata, wstrb: req_wstrb};
    waited    = 0;
    do begin
      @(negedge clk_i);
      waited++;
      // sram port is active in the request cycle only
      if (to_ram && waited == 1) begin
        compare_value("ram_addr_o", ram_addr_o, req_addr >> 2);
        compare_value("ram_wstrb_o", word_t'(ram_wstrb_o), word_t'(req_wstrb));
      end else begin
        compare_value("ram_wstrb_o", word_t'(ram_wstrb_o), '0);
      end
    end while (!bus_ready_o && waited < 4);
    // ready belongs at the second negedge since the first is still in the request cycle
    assert (bus_ready_o && waited == 2) else begin
      other_count++;
      $display("error at %0t: ready for %h not seen exactly one cycle after valid",
               $time, req_addr);
    end
    rdata = bus_rdata_o;
    @(posedge clk_i);
    #DRIVE_DLY;
    bus_req_i = '0;
  endtask

  initial begin
    stim_line_t line;
    word_t      rdata;
    bus_req_i   = '0;
    rst_n_i     = 1'b0;
    ram_rdata_i = '0;
    gpio_in_i   = '0;
    {irq_spi_i, irq_pin_i, trap_i, clk_pll_i, xtal_in_i} = '0;
    chip_info_i = '{chip_cfg: 8'h5a, mfgr_id: 12'h456, prod_id: 8'h3c, mask_rev: 4'h2,
                    clk_ext_sel: 1'b1};
    for (int i = 0; i < FIELDS*MAX_LINES; i++) begin
      stim[i] = '0;
    end
    $readmemh("tb/soc_mmio_stim.txt", stim);
    n_lines = 0;
    while (n_lines < MAX_LINES && stim[n_lines*FIELDS] != '0) begin
      n_lines++;
    end
    timeout_limit = 20 * n_lines + RESET_CYCLES;
    assert (n_lines > 0) else begin
      other_count++;
      $display("error: stimulus file holds no transactions");
    end
    repeat (RESET_CYCLES) begin
      @(posedge clk_i);
      compare_value("gpio_outenb_o", word_t'(gpio_outenb_o), 32'h0000ffff);
    end
    #DRIVE_DLY;
    rst_n_i = 1'b1;
    for (int ln = 0; ln < n_lines; ln++) begin
      line      = fetch_line(ln);
      gpio_in_i = line.gpio_in[15:0];
      {irq_spi_i, irq_pin_i, trap_i, clk_pll_i, xtal_in_i} = line.pins[4:0];
      case (line.op)
        32'd1: begin
          bus_access(line.addr, line.wdata, line.wstrb[3:0], rdata);
          compare_value("bus_rdata_o", rdata, line.exp_rdata);
        end
        32'd2: bus_access(line.addr, line.wdata, line.wstrb[3:0], rdata);
        32'd3: begin
          @(negedge clk_i);
          compare_value("gpio_out_o", word_t'(gpio_out_o), line.exp_out);
          compare_value("gpio_outenb_o", word_t'(gpio_outenb_o), line.exp_oeb);
          compare_value("gpio_pullupb_o", word_t'(gpio_pullupb_o), line.exp_pub);
          compare_value("gpio_pulldownb_o", word_t'(gpio_pulldownb_o), line.exp_pdb);
          compare_value("irq_o", irq_o, line.exp_irq);
          @(posedge clk_i);
          #DRIVE_DLY;
        end
        default: begin
          other_count++;
          $display("error: unknown operation %h on stimulus line %0d", line.op, ln);
        end
      endcase
    end
    $display("checks done: %0d mismatches, %0d other errors", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* source/soc_mmio_top.sv */
// system-control side of the soc as a native bus slave with an external sram port
module soc_mmio_top
  import soc_pkg::*;
#(
  parameter int unsigned MEM_WORDS = 16384
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  bus_req_t   bus_req_i,
  output logic       bus_ready_o,
  output word_t      bus_rdata_o,
  output word_t      ram_addr_o,
  output word_t      ram_wdata_o,
  output strb_t      ram_wstrb_o,
  input  word_t      ram_rdata_i,
  input  gpio_t      gpio_in_i,
  output gpio_t      gpio_out_o,
  output gpio_t      gpio_outenb_o,
  output gpio_t      gpio_pullupb_o,
  output gpio_t      gpio_pulldownb_o,
  input  chip_info_t chip_info_i,
  input  logic       xtal_in_i,
  input  logic       clk_pll_i,
  input  logic       trap_i,
  input  logic       irq_pin_i,
  input  logic       irq_spi_i,
  output word_t      irq_o
);

  sysctl_req_t sysctl_req;
  logic        sysctl_ack;
  word_t       sysctl_rdata;
  gpio_cfg_t   gpio_cfg;
  pin_route_t  route;

  mem_bus_decoder #(
    .MEM_WORDS (MEM_WORDS)
  ) u_decoder (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .bus_req_i      (bus_req_i),
    .bus_ready_o    (bus_ready_o),
    .bus_rdata_o    (bus_rdata_o),
    .ram_addr_o     (ram_addr_o),
    .ram_wdata_o    (ram_wdata_o),
    .ram_wstrb_o    (ram_wstrb_o),
    .ram_rdata_i    (ram_rdata_i),
    .sysctl_req_o   (sysctl_req),
    .sysctl_ack_i   (sysctl_ack),
    .sysctl_rdata_i (sysctl_rdata)
  );

  // gpio readback sees the pads after override
  sysctl_regs u_sysctl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .sysctl_req_i   (sysctl_req),
    .sysctl_ack_o   (sysctl_ack),
    .sysctl_rdata_o (sysctl_rdata),
    .chip_info_i    (chip_info_i),
    .gpio_in_i      (gpio_in_i),
    .gpio_out_i     (gpio_out_o),
    .gpio_cfg_o     (gpio_cfg),
    .route_o        (route)
  );

  gpio_pin_mux u_pin_mux (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .gpio_cfg_i       (gpio_cfg),
    .route_i          (route),
    .gpio_in_i        (gpio_in_i),
    .xtal_in_i        (xtal_in_i),
    .clk_pll_i        (clk_pll_i),
    .trap_i           (trap_i),
    .irq_pin_i        (irq_pin_i),
    .irq_spi_i        (irq_spi_i),
    .gpio_out_o       (gpio_out_o),
    .gpio_outenb_o    (gpio_outenb_o),
    .gpio_pullupb_o   (gpio_pullupb_o),
    .gpio_pulldownb_o (gpio_pulldownb_o),
    .irq_o            (irq_o)
  );

endmodule

/* source/gpio_pin_mux.sv */
// pad override mux and interrupt vector, driven by the system-control register settings
module gpio_pin_mux
  import soc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  gpio_cfg_t  gpio_cfg_i,
  input  pin_route_t route_i,
  input  gpio_t      gpio_in_i,
  input  logic       xtal_in_i,
  input  logic       clk_pll_i,
  input  logic       trap_i,
  input  logic       irq_pin_i,
  input  logic       irq_spi_i,
  output gpio_t      gpio_out_o,
  output gpio_t      gpio_outenb_o,
  output gpio_t      gpio_pullupb_o,
  output gpio_t      gpio_pulldownb_o,
  output word_t      irq_o
);

  // pins taken over by an active routing group
  gpio_t ovr_mask;

  function automatic logic pick_src(logic [1:0] src, logic [2:0] pins);
    logic res;
    case (src)
      2'd1:    res = pins[0];
      2'd2:    res = pins[1];
      2'd3:    res = pins[2];
      default: res = 1'b0;
    endcase
    return res;
  endfunction

  always_comb begin
    ovr_mask   = '0;
    gpio_out_o = gpio_cfg_i.dout;
    case (route_i.xtal_dest)
      DEST_PIN1: gpio_out_o[5] = xtal_in_i;
      DEST_PIN2: gpio_out_o[6] = xtal_in_i;
      DEST_PIN3: gpio_out_o[7] = xtal_in_i;
      default:   ;
    endcase
    // pll dest 3 claims the group but drives nothing
    case (route_i.pll_dest)
      DEST_PIN1: gpio_out_o[8] = clk_pll_i;
      DEST_PIN2: gpio_out_o[9] = clk_i;
      default:   ;
    endcase
    case (route_i.trap_dest)
      DEST_PIN1: gpio_out_o[11] = trap_i;
      DEST_PIN2: gpio_out_o[12] = trap_i;
      DEST_PIN3: gpio_out_o[13] = trap_i;
      default:   ;
    endcase
    if (route_i.xtal_dest != DEST_OFF) begin
      ovr_mask[7:5] = '1;
    end
    if (route_i.pll_dest != DEST_OFF) begin
      ovr_mask[10:8] = '1;
    end
    if (route_i.trap_dest != DEST_OFF) begin
      ovr_mask[13:11] = '1;
    end
  end

  // pads stay tristated until reset is released
  assign gpio_outenb_o    = rst_n_i ? (gpio_cfg_i.oeb & ~ovr_mask) : '1;
  assign gpio_pullupb_o   = gpio_cfg_i.pub | ovr_mask;
  assign gpio_pulldownb_o = gpio_cfg_i.pdb | ovr_mask;

  always_comb begin
    irq_o                = '0;
    irq_o[IRQ_PIN_BIT]   = irq_pin_i;
    irq_o[IRQ_SPI_BIT]   = irq_spi_i;
    irq_o[IRQ_GPIO7_BIT] = pick_src(route_i.irq7_src, gpio_in_i[2:0]);
    irq_o[IRQ_GPIO8_BIT] = pick_src(route_i.irq8_src, gpio_in_i[5:3]);
  end

  // also covers the first edge after release, relying on the register reset values
  a_oeb_high_in_reset: assert property (
    @(posedge clk_i) (!rst_n_i || $rose(rst_n_i)) |-> &gpio_outenb_o
  );

endmodule

/* source/sysctl_regs.sv */
// system-control register file with gpio pad config, pad routing, irq sources and chip identity
module sysctl_regs
  import soc_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  sysctl_req_t sysctl_req_i,
  output logic        sysctl_ack_o,
  output word_t       sysctl_rdata_o,
  input  chip_info_t  chip_info_i,
  input  gpio_t       gpio_in_i,
  input  gpio_t       gpio_out_i,
  output gpio_cfg_t   gpio_cfg_o,
  output pin_route_t  route_o
);

  gpio_cfg_t  cfg_q;
  pin_route_t route_q;
  logic       ack_q;
  word_t      rdata_q;
  word_t      rdata_next;

  // low byte on strobe 0, high byte on strobe 1
  function automatic gpio_t merge_bytes(gpio_t cur, word_t wdata, strb_t wstrb);
    gpio_t res;
    res = cur;
    if (wstrb[0]) begin
      res[7:0] = wdata[7:0];
    end
    if (wstrb[1]) begin
      res[15:8] = wdata[15:8];
    end
    return res;
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q.dout <= '0;
      cfg_q.oeb  <= '1;
      cfg_q.pub  <= '0;
      cfg_q.pdb  <= '0;
      route_q    <= '0;
      ack_q      <= 1'b0;
    end else begin
      ack_q <= sysctl_req_i.sel;
      if (sysctl_req_i.sel) begin
        case (sysctl_req_i.offset)
          OFF_GPIO: begin
            cfg_q.dout <= merge_bytes(cfg_q.dout, sysctl_req_i.wdata, sysctl_req_i.wstrb);
          end
          OFF_OEB: begin
            cfg_q.oeb <= merge_bytes(cfg_q.oeb, sysctl_req_i.wdata, sysctl_req_i.wstrb);
          end
          OFF_PU: begin
            cfg_q.pub <= merge_bytes(cfg_q.pub, sysctl_req_i.wdata, sysctl_req_i.wstrb);
          end
          OFF_PD: begin
            cfg_q.pdb <= merge_bytes(cfg_q.pdb, sysctl_req_i.wdata, sysctl_req_i.wstrb);
          end
          OFF_XTAL: begin
            if (sysctl_req_i.wstrb[0]) begin
              route_q.xtal_dest <= pin_dest_t'(sysctl_req_i.wdata[1:0]);
            end
          end
          OFF_PLL: begin
            if (sysctl_req_i.wstrb[0]) begin
              route_q.pll_dest <= pin_dest_t'(sysctl_req_i.wdata[1:0]);
            end
          end
          OFF_TRAP: begin
            if (sysctl_req_i.wstrb[0]) begin
              route_q.trap_dest <= pin_dest_t'(sysctl_req_i.wdata[1:0]);
            end
          end
          OFF_IRQ7: begin
            if (sysctl_req_i.wstrb[0]) begin
              route_q.irq7_src <= sysctl_req_i.wdata[1:0];
            end
          end
          OFF_IRQ8: begin
            if (sysctl_req_i.wstrb[0]) begin
              route_q.irq8_src <= sysctl_req_i.wdata[1:0];
            end
          end
          default: ;
        endcase
      end
    end
  end

  // read returns contents from before a write in the same access
  always_comb begin
    case (sysctl_req_i.offset)
      OFF_GPIO:   rdata_next = {gpio_out_i, gpio_in_i};
      OFF_OEB:    rdata_next = {16'd0, cfg_q.oeb};
      OFF_PU:     rdata_next = {16'd0, cfg_q.pub};
      OFF_PD:     rdata_next = {16'd0, cfg_q.pdb};
      OFF_CONFIG: rdata_next = {24'd0, chip_info_i.chip_cfg};
      OFF_MFGR:   rdata_next = {20'd0, chip_info_i.mfgr_id};
      OFF_PROD:   rdata_next = {24'd0, chip_info_i.prod_id};
      OFF_MASK:   rdata_next = {28'd0, chip_info_i.mask_rev};
      OFF_CLKSEL: rdata_next = {31'd0, chip_info_i.clk_ext_sel};
      OFF_XTAL:   rdata_next = {30'd0, route_q.xtal_dest};
      OFF_PLL:    rdata_next = {30'd0, route_q.pll_dest};
      OFF_TRAP:   rdata_next = {30'd0, route_q.trap_dest};
      OFF_IRQ7:   rdata_next = {30'd0, route_q.irq7_src};
      OFF_IRQ8:   rdata_next = {30'd0, route_q.irq8_src};
      default:    rdata_next = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (sysctl_req_i.sel) begin
      rdata_q <= rdata_next;
    end
  end

  assign sysctl_ack_o   = ack_q;
  assign sysctl_rdata_o = rdata_q;
  assign gpio_cfg_o     = cfg_q;
  assign route_o        = route_q;

  // decoder drops sel in the ack cycle so an ack never repeats
  a_ack_releases_sel: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) sysctl_ack_o |-> !sysctl_req_i.sel
  );

endmodule

/* source/mem_bus_decoder.sv */
// native bus slave front end, steers each request to RAM, system control or unmapped space
module mem_bus_decoder
  import soc_pkg::*;
#(
  parameter int unsigned MEM_WORDS = 16384
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  bus_req_t    bus_req_i,
  output logic        bus_ready_o,
  output word_t       bus_rdata_o,
  output word_t       ram_addr_o,
  output word_t       ram_wdata_o,
  output strb_t       ram_wstrb_o,
  input  word_t       ram_rdata_i,
  output sysctl_req_t sysctl_req_o,
  input  logic        sysctl_ack_i,
  input  word_t       sysctl_rdata_i
);

  localparam int unsigned RAM_AW = $clog2(MEM_WORDS);

  typedef enum logic [1:0] {
    REGION_RAM,
    REGION_SYSCTL,
    REGION_UNMAP
  } region_e;

  region_e region;
  logic    pending;
  logic    ram_ready_q;
  logic    unmap_ready_q;

  always_comb begin
    if (bus_req_i.addr < addr_t'(4 * MEM_WORDS)) begin
      region = REGION_RAM;
    end else if (bus_req_i.addr[31:24] == SYSCTL_BASE) begin
      region = REGION_SYSCTL;
    end else begin
      region = REGION_UNMAP;
    end
  end

  // request seen but not yet answered
  assign pending = bus_req_i.valid && !bus_ready_o;

  assign ram_addr_o  = word_t'(bus_req_i.addr[RAM_AW+1:2]);
  assign ram_wdata_o = bus_req_i.wdata;
  assign ram_wstrb_o = (pending && region == REGION_RAM) ? bus_req_i.wstrb : '0;

  assign sysctl_req_o.sel    = pending && region == REGION_SYSCTL;
  assign sysctl_req_o.offset = bus_req_i.addr[7:0];
  assign sysctl_req_o.wdata  = bus_req_i.wdata;
  assign sysctl_req_o.wstrb  = bus_req_i.wstrb;

  // sram answers one cycle after the request, unmapped space likewise
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ram_ready_q   <= 1'b0;
      unmap_ready_q <= 1'b0;
    end else begin
      ram_ready_q   <= pending && region == REGION_RAM;
      unmap_ready_q <= pending && region == REGION_UNMAP;
    end
  end

  assign bus_ready_o = ram_ready_q | unmap_ready_q | sysctl_ack_i;

  always_comb begin
    bus_rdata_o = '0;
    if (ram_ready_q) begin
      bus_rdata_o = ram_rdata_i;
    end else if (sysctl_ack_i) begin
      bus_rdata_o = sysctl_rdata_i;
    end
  end

  a_ready_has_valid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) bus_ready_o |-> bus_req_i.valid
  );

  a_ready_single_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) bus_ready_o |=> !bus_ready_o
  );

endmodule

/* source/soc_pkg.sv */
// shared types, address map and register offsets, imported by every design module
package soc_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  strb_t;
  typedef logic [15:0] gpio_t;
  typedef logic [7:0]  reg_off_t;

  // which pad of a group an internal signal is routed to
  typedef enum logic [1:0] {
    DEST_OFF  = 2'd0,
    DEST_PIN1 = 2'd1,
    DEST_PIN2 = 2'd2,
    DEST_PIN3 = 2'd3
  } pin_dest_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    word_t wdata;
    strb_t wstrb;
  } bus_req_t;

  typedef struct packed {
    logic     sel;
    reg_off_t offset;
    word_t    wdata;
    strb_t    wstrb;
  } sysctl_req_t;

  // config is a reserved word, so the field is chip_cfg
  typedef struct packed {
    logic [7:0]  chip_cfg;
    logic [11:0] mfgr_id;
    logic [7:0]  prod_id;
    logic [3:0]  mask_rev;
    logic        clk_ext_sel;
  } chip_info_t;

  typedef struct packed {
    pin_dest_t  xtal_dest;
    pin_dest_t  pll_dest;
    pin_dest_t  trap_dest;
    logic [1:0] irq7_src;
    logic [1:0] irq8_src;
  } pin_route_t;

  typedef struct packed {
    gpio_t dout;
    gpio_t oeb;
    gpio_t pub;
    gpio_t pdb;
  } gpio_cfg_t;

  localparam logic [7:0] SYSCTL_BASE = 8'h03;

  localparam reg_off_t OFF_GPIO   = 8'h00;
  localparam reg_off_t OFF_OEB    = 8'h04;
  localparam reg_off_t OFF_PU     = 8'h08;
  localparam reg_off_t OFF_PD     = 8'h0c;
  // identity, read only
  localparam reg_off_t OFF_CONFIG = 8'h18;
  localparam reg_off_t OFF_MFGR   = 8'h24;
  localparam reg_off_t OFF_PROD   = 8'h28;
  localparam reg_off_t OFF_MASK   = 8'h2c;
  localparam reg_off_t OFF_CLKSEL = 8'h30;
  // pad routing and irq sources
  localparam reg_off_t OFF_XTAL   = 8'h34;
  localparam reg_off_t OFF_PLL    = 8'h38;
  localparam reg_off_t OFF_TRAP   = 8'h3c;
  localparam reg_off_t OFF_IRQ7   = 8'h40;
  localparam reg_off_t OFF_IRQ8   = 8'h44;

  localparam int unsigned IRQ_PIN_BIT   = 5;
  localparam int unsigned IRQ_SPI_BIT   = 6;
  localparam int unsigned IRQ_GPIO7_BIT = 7;
  localparam int unsigned IRQ_GPIO8_BIT = 8;

endpackage
